// File: attn.f
design/attn_pkg.sv
design/attn_input_buffer.sv
design/attn_sequencer.sv
design/attn_projection.sv
design/attn_score.sv
design/attn_weighted_sum.sv
design/attn_top.sv
testbench/attn_clock_gen.sv
testbench/attn_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the attention engine testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module attn_tb -f attn.f -o attn_sim || exit 1

sim_out=$(./obj_dir/attn_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/attn_tb.sv
`timescale 1ns/100ps

module attn_tb;
    import attn_pkg::*;

    localparam int NUM_CASES = 10;
    localparam int SEED      = 14526;

    typedef enum logic [1:0] {
        MODE_RANDOM,
        MODE_MAX,
        MODE_MIN,
        MODE_NEG
    } mode_e;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic [3:0] t;
    elem_t      in_data;
    elem_t      w_q;
    elem_t      w_k;
    elem_t      w_v;
    logic       out_valid;
    out_t       out_data;

    // ##############################
    // case table
    // ##############################
    string      case_name [NUM_CASES];
    logic [3:0] case_t    [NUM_CASES];
    mode_e      case_mode [NUM_CASES];
    // expected row count for each T code
    int         case_rows [NUM_CASES];

    int     x_m  [DIM][DIM];
    int     wq_m [DIM][DIM];
    int     wk_m [DIM][DIM];
    int     wv_m [DIM][DIM];
    longint q_m  [DIM][DIM];
    longint k_m  [DIM][DIM];
    longint v_m  [DIM][DIM];
    longint s_m  [DIM][DIM];
    longint exp_out [MAX_ROWS*DIM];
    int     errors;
    logic   table_ready;

    attn_clock_gen clk_gen0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    attn_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t         (t),
        .in_data   (in_data),
        .w_q       (w_q),
        .w_k       (w_k),
        .w_v       (w_v),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    task automatic check_value(input string what, input longint expected, input longint actual);
        if (expected != actual) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", what, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopping at the first wrong value");
        end
    endtask

    task automatic set_case(input int i, input string name, input logic [3:0] code,
                            input mode_e mode, input int rows);
        case_name[i] = name;
        case_t[i]    = code;
        case_mode[i] = mode;
        case_rows[i] = rows;
    endtask

    // every job starts the cycle after the previous one ends
    task automatic fill_table();
        set_case(0, "t1_random", 4'd1, MODE_RANDOM, 1);
        set_case(1, "t4_random", 4'd4, MODE_RANDOM, 4);
        set_case(2, "t8_random", 4'd8, MODE_RANDOM, 8);
        set_case(3, "t0_as_8", 4'd0, MODE_RANDOM, 8);
        set_case(4, "t15_as_8", 4'd15, MODE_RANDOM, 8);
        set_case(5, "clip_negative", 4'd4, MODE_NEG, 4);
        set_case(6, "all_max", 4'd8, MODE_MAX, 8);
        set_case(7, "all_min", 4'd8, MODE_MIN, 8);
        // old S rows of a full job must not leak into a smaller T
        set_case(8, "t1_after_t8", 4'd1, MODE_RANDOM, 1);
        set_case(9, "t4_after_t1", 4'd4, MODE_RANDOM, 4);
    endtask

    function automatic int random_elem();
        return int'($urandom_range(255)) - 128;
    endfunction

    // worst case cycles per job over load, projections, score, sum and gaps plus slack
    function automatic int case_cycles(input int rows);
        return LOAD_CYCLES + 4*rows*DIM + rows*rows + 5*PIPE_DEPTH + 20;
    endfunction

    task automatic fill_data(input mode_e mode);
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                case (mode)
                    MODE_MAX: begin
                        x_m[r][c]  = 127;
                        wq_m[r][c] = 127;
                        wk_m[r][c] = 127;
                        wv_m[r][c] = 127;
                    end
                    MODE_MIN: begin
                        x_m[r][c]  = -128;
                        wq_m[r][c] = -128;
                        wk_m[r][c] = -128;
                        wv_m[r][c] = -128;
                    end
                    MODE_NEG: begin
                        // Q all positive and K all negative
                        x_m[r][c]  = 1;
                        wq_m[r][c] = 1;
                        wk_m[r][c] = -1;
                        wv_m[r][c] = r*DIM + c - 32;
                    end
                    default: begin
                        x_m[r][c]  = random_elem();
                        wq_m[r][c] = random_elem();
                        wk_m[r][c] = random_elem();
                        wv_m[r][c] = random_elem();
                    end
                endcase
            end
        end
    endtask

    // ##############################
    // reference model
    // ##############################
    task automatic compute_expected(input int rows);
        longint acc;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < DIM; c++) begin
                q_m[r][c] = 0;
                k_m[r][c] = 0;
                v_m[r][c] = 0;
                for (int i = 0; i < DIM; i++) begin
                    q_m[r][c] += longint'(x_m[r][i]) * wq_m[i][c];
                    k_m[r][c] += longint'(x_m[r][i]) * wk_m[i][c];
                    v_m[r][c] += longint'(x_m[r][i]) * wv_m[i][c];
                end
            end
        end
        // negative dot products clip to zero before the truncating divide
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < rows; c++) begin
                acc = 0;
                for (int i = 0; i < DIM; i++) begin
                    acc += q_m[r][i] * k_m[c][i];
                end
                s_m[r][c] = (acc < 0) ? 0 : acc / 3;
            end
        end
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < DIM; c++) begin
                acc = 0;
                for (int k = 0; k < rows; k++) begin
                    acc += s_m[r][k] * v_m[k][c];
                end
                exp_out[r*DIM + c] = acc;
            end
        end
    endtask

    // starts and ends on a falling edge
    task automatic run_case(input int n);
        int rows;
        int idx;
        rows = case_rows[n];
        fill_data(case_mode[n]);
        compute_expected(rows);
        for (int j = 0; j < LOAD_CYCLES; j++) begin
            check_value($sformatf("%s out_valid during load", case_name[n]), 0,
                        longint'(out_valid));
            check_value($sformatf("%s out_data during load", case_name[n]), 0,
                        longint'(out_data));
            in_valid = 1'b1;
            t        = case_t[n];
            // X past T rows is junk that the DUT must ignore
            in_data  = (j < rows*DIM) ? 8'(x_m[j/DIM][j%DIM]) : 8'($urandom);
            w_q      = (j < W_BLOCK) ? 8'(wq_m[j/DIM][j%DIM]) : '0;
            w_k      = (j >= W_BLOCK && j < 2*W_BLOCK) ?
                       8'(wk_m[(j-W_BLOCK)/DIM][j%DIM]) : '0;
            w_v      = (j >= 2*W_BLOCK) ? 8'(wv_m[(j-2*W_BLOCK)/DIM][j%DIM]) : '0;
            @(negedge clk);
        end
        in_valid = 1'b0;
        // t is only sampled at the start of a burst
        t        = 4'd0;
        in_data  = '0;
        w_q      = '0;
        w_k      = '0;
        w_v      = '0;
        while (!out_valid) begin
            check_value($sformatf("%s idle out_data", case_name[n]), 0, longint'(out_data));
            @(negedge clk);
        end
        idx = 0;
        while (out_valid) begin
            if (idx < rows*DIM) begin
                check_value($sformatf("%s row %0d col %0d", case_name[n], idx/DIM, idx%DIM),
                            exp_out[idx], longint'(out_data));
            end
            idx++;
            @(negedge clk);
        end
        check_value($sformatf("%s out_valid length", case_name[n]), rows*DIM, idx);
    endtask

    // ##############################
    // main sequence
    // ##############################
    initial begin
        in_valid    = 1'b0;
        t           = 4'd0;
        in_data     = '0;
        w_q         = '0;
        w_k         = '0;
        w_v         = '0;
        errors      = 0;
        table_ready = 1'b0;
        void'($urandom(SEED));
        fill_table();
        table_ready = 1'b1;
        @(posedge rst_n);
        repeat (3) begin
            @(negedge clk);
            check_value("after reset out_valid", 0, longint'(out_valid));
            check_value("after reset out_data", 0, longint'(out_data));
        end
        for (int n = 0; n < NUM_CASES; n++) begin
            run_case(n);
        end
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized from the case table
    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = 20;
        for (int n = 0; n < NUM_CASES; n++) begin
            limit += case_cycles(case_rows[n]);
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the DUT did not finish all jobs within %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: testbench/attn_clock_gen.sv
`timescale 1ns/100ps

module attn_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: design/attn_top.sv
`timescale 1ns/100ps

module attn_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic [3:0]      t,
    input  attn_pkg::elem_t in_data,
    input  attn_pkg::elem_t w_q,
    input  attn_pkg::elem_t w_k,
    input  attn_pkg::elem_t w_v,
    output logic            out_valid,
    output attn_pkg::out_t  out_data
);
    import attn_pkg::*;

    step_t      step;
    load_t      load;
    elem_mat_t  x_mat;
    elem_mat_t  wq_mat;
    elem_mat_t  wk_mat;
    elem_mat_t  wv_mat;
    proj_mat_t  q_mat;
    proj_mat_t  k_mat;
    proj_mat_t  v_mat;
    score_mat_t s_mat;

    // input streams tagged with the sequencer's load position
    assign load = '{x: in_data, wq: w_q, wk: w_k, wv: w_v, load_idx: step.load_idx};

    attn_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .t        (t),
        .step     (step)
    );

    attn_input_buffer u_buf (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .step   (step),
        .x_mat  (x_mat),
        .wq_mat (wq_mat),
        .wk_mat (wk_mat),
        .wv_mat (wv_mat)
    );

    attn_projection u_proj (
        .clk    (clk),
        .rst_n  (rst_n),
        .step   (step),
        .x_mat  (x_mat),
        .wq_mat (wq_mat),
        .wk_mat (wk_mat),
        .wv_mat (wv_mat),
        .q_mat  (q_mat),
        .k_mat  (k_mat),
        .v_mat  (v_mat)
    );

    attn_score u_score (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (step),
        .q_mat (q_mat),
        .k_mat (k_mat),
        .s_mat (s_mat)
    );

    attn_weighted_sum u_wsum (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .s_mat     (s_mat),
        .v_mat     (v_mat),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: design/attn_weighted_sum.sv
`timescale 1ns/100ps

module attn_weighted_sum (
    input  logic                 clk,
    input  logic                 rst_n,
    input  attn_pkg::step_t      step,
    input  attn_pkg::score_mat_t s_mat,
    input  attn_pkg::proj_mat_t  v_mat,
    output logic                 out_valid,
    output attn_pkg::out_t       out_data
);
    import attn_pkg::*;

    logic wsum_hit;
    logic valid_d;
    out_t prod [DIM];
    out_t wsum;

    assign wsum_hit = step.valid && (step.phase == PH_WSUM);

    // ##############################
    // stage 1, S row times V column
    // ##############################
    always_ff @(posedge clk) begin
        if (wsum_hit) begin
            for (int k = 0; k < DIM; k++) begin
                // zero-extend S so the unsigned score stays positive
                prod[k] <= $signed({1'b0, s_mat[step.row][k]}) *
                           $signed(v_mat[k][step.col]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= wsum_hit;
        end
    end

    always_comb begin
        wsum = '0;
        for (int k = 0; k < DIM; k++) begin
            wsum = wsum + prod[k];
        end
    end

    // ##############################
    // stage 2, output register
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= valid_d;
            // bus idles at zero between results
            out_data  <= valid_d ? wsum : '0;
        end
    end

endmodule

// File: design/attn_score.sv
`timescale 1ns/100ps

module attn_score (
    input  logic                 clk,
    input  logic                 rst_n,
    input  attn_pkg::step_t      step,
    input  attn_pkg::proj_mat_t  q_mat,
    input  attn_pkg::proj_mat_t  k_mat,
    output attn_pkg::score_mat_t s_mat
);
    import attn_pkg::*;

    logic                       score_hit;
    logic                       clear;
    logic signed [2*PROJ_W-1:0] prod [DIM];
    step_t                      step_d;
    // sign bit plus the full score range
    logic signed [SCORE_W:0]    dot;
    score_t                     dot_pos;
    score_t                     score_val;

    assign score_hit = step.valid && (step.phase == PH_SCORE);
    // a fresh job starts with S all zero, so entries past T read as zero
    assign clear     = step.valid && (step.phase == PH_LOAD);

    // ##############################
    // stage 1, Q row times K row
    // ##############################
    always_ff @(posedge clk) begin
        if (score_hit) begin
            for (int i = 0; i < DIM; i++) begin
                prod[i] <= $signed(q_mat[step.row][i]) * $signed(k_mat[step.col][i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_d <= '0;
        end else begin
            step_d <= step;
        end
    end

    // ##############################
    // stage 2, sum, clip and divide
    // ##############################
    always_comb begin
        dot = '0;
        for (int i = 0; i < DIM; i++) begin
            dot = dot + prod[i];
        end
    end

    // negative scores clip to zero before the divide
    assign dot_pos   = dot[SCORE_W] ? '0 : dot[SCORE_W-1:0];
    assign score_val = dot_pos / 3;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_mat <= '0;
        end else if (clear) begin
            s_mat <= '0;
        end else if (step_d.valid && (step_d.phase == PH_SCORE)) begin
            s_mat[step_d.row][step_d.col] <= score_val;
        end
    end

endmodule

// File: design/attn_projection.sv
`timescale 1ns/100ps

module attn_projection (
    input  logic                clk,
    input  logic                rst_n,
    input  attn_pkg::step_t     step,
    input  attn_pkg::elem_mat_t x_mat,
    input  attn_pkg::elem_mat_t wq_mat,
    input  attn_pkg::elem_mat_t wk_mat,
    input  attn_pkg::elem_mat_t wv_mat,
    output attn_pkg::proj_mat_t q_mat,
    output attn_pkg::proj_mat_t k_mat,
    output attn_pkg::proj_mat_t v_mat
);
    import attn_pkg::*;

    logic                       proj_hit;
    elem_mat_t                  w_sel;
    logic signed [2*ELEM_W-1:0] prod [DIM];
    step_t                      step_d;
    proj_t                      proj_sum;

    assign proj_hit = step.valid &&
                      (step.phase inside {PH_PROJ_Q, PH_PROJ_K, PH_PROJ_V});

    always_comb begin
        case (step.phase)
            PH_PROJ_K: w_sel = wk_mat;
            PH_PROJ_V: w_sel = wv_mat;
            default:   w_sel = wq_mat;
        endcase
    end

    // ##############################
    // stage 1, eight lane products
    // ##############################
    always_ff @(posedge clk) begin
        if (proj_hit) begin
            for (int i = 0; i < DIM; i++) begin
                prod[i] <= $signed(x_mat[step.row][i]) * $signed(w_sel[i][step.col]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_d <= '0;
        end else begin
            step_d <= step;
        end
    end

    // ##############################
    // stage 2, sum into Q, K or V
    // ##############################
    always_comb begin
        proj_sum = '0;
        for (int i = 0; i < DIM; i++) begin
            proj_sum = proj_sum + prod[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_mat <= '0;
            k_mat <= '0;
            v_mat <= '0;
        end else if (step_d.valid) begin
            case (step_d.phase)
                PH_PROJ_Q: q_mat[step_d.row][step_d.col] <= proj_sum;
                PH_PROJ_K: k_mat[step_d.row][step_d.col] <= proj_sum;
                PH_PROJ_V: v_mat[step_d.row][step_d.col] <= proj_sum;
                default: begin
                end
            endcase
        end
    end

endmodule

// File: design/attn_sequencer.sv
`timescale 1ns/100ps

module attn_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic [3:0]      t,
    output attn_pkg::step_t step
);
    import attn_pkg::*;

    phase_e     phase_q;
    phase_e     phase_d;
    logic       gap_q;
    logic       gap_d;
    logic [7:0] cnt_q;
    logic [7:0] cnt_d;
    logic [2:0] row_q;
    logic [2:0] row_d;
    logic [2:0] col_q;
    logic [2:0] col_d;
    logic [2:0] rows_m1_q;
    logic [2:0] last_col;
    logic       in_valid_q;
    logic       start;

    // only the first cycle of a burst seen while idle starts a job
    assign start = (phase_q == PH_IDLE) && in_valid && !in_valid_q;

    // score walks a T x T grid, the other phases T x 8
    assign last_col = (phase_q == PH_SCORE) ? rows_m1_q : 3'(DIM - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q    <= PH_IDLE;
            gap_q      <= 1'b0;
            cnt_q      <= '0;
            row_q      <= '0;
            col_q      <= '0;
            in_valid_q <= 1'b0;
        end else begin
            phase_q    <= phase_d;
            gap_q      <= gap_d;
            cnt_q      <= cnt_d;
            row_q      <= row_d;
            col_q      <= col_d;
            in_valid_q <= in_valid;
        end
    end

    // T codes other than 1 and 4 run as a full matrix
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rows_m1_q <= 3'(MAX_ROWS - 1);
        end else if (start) begin
            case (t)
                4'd1:    rows_m1_q <= 3'd0;
                4'd4:    rows_m1_q <= 3'd3;
                default: rows_m1_q <= 3'(MAX_ROWS - 1);
            endcase
        end
    end

    // ##############################
    // phase FSM
    // ##############################
    always_comb begin
        phase_d = phase_q;
        gap_d   = gap_q;
        cnt_d   = cnt_q;
        row_d   = row_q;
        col_d   = col_q;
        case (phase_q)
            PH_IDLE: begin
                if (start) begin
                    phase_d = PH_LOAD;
                    cnt_d   = 8'd1;
                end
            end
            PH_LOAD: begin
                if (cnt_q == 8'(LOAD_CYCLES - 1)) begin
                    phase_d = PH_PROJ_Q;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_q + 8'd1;
                end
            end
            PH_DRAIN: begin
                // long enough for the weighted sum pipeline to empty
                if (cnt_q == 8'(PIPE_DEPTH - 2)) begin
                    phase_d = PH_IDLE;
                end else begin
                    cnt_d = cnt_q + 8'd1;
                end
            end
            default: begin
                if (gap_q) begin
                    if (cnt_q == 8'(PIPE_DEPTH - 1)) begin
                        gap_d = 1'b0;
                        cnt_d = '0;
                        case (phase_q)
                            PH_PROJ_Q: phase_d = PH_PROJ_K;
                            PH_PROJ_K: phase_d = PH_PROJ_V;
                            PH_PROJ_V: phase_d = PH_SCORE;
                            default:   phase_d = PH_WSUM;
                        endcase
                    end else begin
                        cnt_d = cnt_q + 8'd1;
                    end
                end else if (col_q == last_col) begin
                    col_d = '0;
                    if (row_q == rows_m1_q) begin
                        row_d = '0;
                        cnt_d = '0;
                        if (phase_q == PH_WSUM) begin
                            phase_d = PH_DRAIN;
                        end else begin
                            gap_d = 1'b1;
                        end
                    end else begin
                        row_d = row_q + 3'd1;
                    end
                end else begin
                    col_d = col_q + 3'd1;
                end
            end
        endcase
    end

    // the first load step goes out in the same cycle as the first in_valid
    always_comb begin
        step.phase    = phase_q;
        step.row      = row_q;
        step.col      = col_q;
        step.load_idx = cnt_q;
        step.valid    = !gap_q && (phase_q != PH_IDLE) && (phase_q != PH_DRAIN);
        if (start) begin
            step.phase    = PH_LOAD;
            step.load_idx = '0;
            step.valid    = 1'b1;
        end
    end

endmodule

// File: design/attn_input_buffer.sv
`timescale 1ns/100ps

module attn_input_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  attn_pkg::load_t     load,
    input  attn_pkg::step_t     step,
    output attn_pkg::elem_mat_t x_mat,
    output attn_pkg::elem_mat_t wq_mat,
    output attn_pkg::elem_mat_t wk_mat,
    output attn_pkg::elem_mat_t wv_mat
);
    import attn_pkg::*;

    logic       load_en;
    logic [2:0] row;
    logic [2:0] col;

    assign load_en = step.valid && (step.phase == PH_LOAD);

    // row-major position inside the current 64-cycle block
    assign row = load.load_idx[5:3];
    assign col = load.load_idx[2:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_mat  <= '0;
            wq_mat <= '0;
            wk_mat <= '0;
            wv_mat <= '0;
        end else if (load_en) begin
            // X lives in the first block only, rows past T are never read
            if (load.load_idx < W_BLOCK) begin
                x_mat[row][col] <= load.x;
            end
            // each weight stream owns one block of the burst
            case (load.load_idx[7:6])
                2'd0: begin
                    wq_mat[row][col] <= load.wq;
                end
                2'd1: begin
                    wk_mat[row][col] <= load.wk;
                end
                2'd2: begin
                    wv_mat[row][col] <= load.wv;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: design/attn_pkg.sv
package attn_pkg;

    // ##############################
    // sizes and widths
    // ##############################
    localparam int DIM         = 8;
    localparam int MAX_ROWS    = 8;
    localparam int LOAD_CYCLES = 192;
    localparam int W_BLOCK     = 64;
    localparam int ELEM_W      = 8;
    localparam int PROJ_W      = 19;
    localparam int SCORE_W     = 40;
    localparam int OUT_W       = 61;
    localparam int PIPE_DEPTH  = 3;

    // ##############################
    // element and matrix types
    // ##############################
    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [PROJ_W-1:0] proj_t;
    // clipped at zero, no sign bit needed
    typedef logic [SCORE_W-1:0]       score_t;
    typedef logic signed [OUT_W-1:0]  out_t;

    // indexed [row][col]
    typedef elem_t  [DIM-1:0][DIM-1:0] elem_mat_t;
    typedef proj_t  [DIM-1:0][DIM-1:0] proj_mat_t;
    typedef score_t [DIM-1:0][DIM-1:0] score_mat_t;

    // ##############################
    // control
    // ##############################
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LOAD,
        PH_PROJ_Q,
        PH_PROJ_K,
        PH_PROJ_V,
        PH_SCORE,
        PH_WSUM,
        PH_DRAIN
    } phase_e;

    // one command per cycle from the sequencer
    typedef struct packed {
        phase_e     phase;
        logic [2:0] row;
        logic [2:0] col;
        logic [7:0] load_idx;
        logic       valid;
    } step_t;

    // one cycle of the input streams
    typedef struct packed {
        elem_t      x;
        elem_t      wq;
        elem_t      wk;
        elem_t      wv;
        logic [7:0] load_idx;
    } load_t;

endpackage
